/* compile.f */
hdl/bchPkg.sv
hdl/bchIfs.sv
hdl/decodeControl.sv
hdl/syndromeCalc.sv
hdl/berlekampSerial.sv
hdl/chienSearch.sv
hdl/bitDelayBuffer.sv
hdl/bchDecoder.sv
tb/clockGen.sv
tb/bchDecoderTb.sv

/* hdl/bchDecoder.sv */
`default_nettype none

module bchDecoder (
	input logic clk,
	input logic reset,
	input logic dataIn,
	output logic dataOut,
	output logic outValid
);

	logic synLoad;
	logic bmStart;
	logic bmStepEn;
	logic chienStart;
	logic bufBit;
	logic [1:0] iterIdx;

	syndromeIf synBus ();
	errLocIf locBus ();

	// framePos is left open, kept for debug probing
	decodeControl ctrl_i (
		.clk(clk),
		.reset(reset),
		.synLoad(synLoad),
		.bmStart(bmStart),
		.bmStepEn(bmStepEn),
		.chienStart(chienStart),
		.outValid(outValid),
		.iterIdx(iterIdx),
		.framePos()
	);

	syndromeCalc syn_i (
		.clk(clk),
		.reset(reset),
		.dataIn(dataIn),
		.synLoad(synLoad),
		.syn(synBus.source)
	);

	berlekampSerial bm_i (
		.clk(clk),
		.reset(reset),
		.bmStart(bmStart),
		.bmStepEn(bmStepEn),
		.iterIdx(iterIdx),
		.syn(synBus.sink),
		.errLoc(locBus.source)
	);

	bitDelayBuffer delay_i (
		.clk(clk),
		.reset(reset),
		.dataIn(dataIn),
		.bufBit(bufBit)
	);

	chienSearch chien_i (
		.clk(clk),
		.reset(reset),
		.chienStart(chienStart),
		.bufBit(bufBit),
		.errLoc(locBus.sink),
		.dataOut(dataOut)
	);

endmodule

`default_nettype wire

/* hdl/bchIfs.sv */
`default_nettype none

interface syndromeIf;
	import bchPkg::*;

	gfElem s1;
	gfElem s3;
	gfElem s5;
	logic valid;

	modport source (output s1, s3, s5, valid);
	modport sink (input s1, s3, s5, valid);
endinterface

interface errLocIf;
	import bchPkg::*;

	gfElem sigma1;
	gfElem sigma2;
	gfElem sigma3;
	logic valid;

	modport source (output sigma1, sigma2, sigma3, valid);
	modport sink (input sigma1, sigma2, sigma3, valid);
endinterface

`default_nettype wire

/* hdl/bchPkg.sv */
`default_nettype none

package bchPkg;

	localparam int codeLen = 15;
	localparam int msgLen = 5;
	localparam int maxErr = 3;
	localparam int fieldBits = 4;
	localparam int iterCycles = 4;
	localparam int posWidth = 4;

	// x^4 + x + 1
	localparam logic [fieldBits:0] primPoly = 5'h13;

	typedef logic [fieldBits-1:0] gfElem;

	localparam gfElem alpha = 4'h2;

	function automatic gfElem gfMul(gfElem a, gfElem b);
		gfElem acc;
		gfElem sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < fieldBits; i++) begin
			if (b[i])
				acc ^= sh;
			// multiply by x, reduce when the top bit falls out
			sh = {sh[fieldBits-2:0], 1'b0} ^ (sh[fieldBits-1] ? primPoly[fieldBits-1:0] : '0);
		end
		return acc;
	endfunction

	function automatic gfElem gfPow(gfElem a, int unsigned e);
		gfElem r;
		r = gfElem'(1);
		for (int unsigned i = 0; i < codeLen; i++) begin
			if (i < e % codeLen)
				r = gfMul(r, a);
		end
		return r;
	endfunction

endpackage

`default_nettype wire

/* hdl/berlekampSerial.sv */
`default_nettype none

module berlekampSerial (
	input logic clk,
	input logic reset,
	input logic bmStart,
	input logic bmStepEn,
	input logic [1:0] iterIdx,
	syndromeIf.sink syn,
	errLocIf.source errLoc
);
	import bchPkg::*;

	// S0 is held at zero so out-of-range terms drop out
	gfElem synVal [0:5];
	// sigma0 is always 1 and not stored
	gfElem sigma [1:3];
	gfElem sigNext [1:3];
	gfElem corr [0:2];
	gfElem dInv;
	gfElem disc;
	gfElem factor;
	gfElem mulA;
	gfElem mulB;
	gfElem prod;
	logic [2:0] degL;
	logic [1:0] phase;
	logic [3:0] synIdx;
	logic lenChange;
	logic lastStep;

	// one shared multiplier: sigma(phase+1) * S(2k-phase)
	always_comb begin
		case (phase)
			2'd0: mulA = sigma[1];
			2'd1: mulA = sigma[2];
			default: mulA = sigma[3];
		endcase
		synIdx = {1'b0, iterIdx, 1'b0} - {2'b00, phase};
		mulB = (synIdx > 4'd5) ? '0 : synVal[synIdx[2:0]];
		prod = gfMul(mulA, mulB);

		factor = gfMul(disc, dInv);
		for (int i = 1; i <= maxErr; i++)
			sigNext[i] = sigma[i] ^ gfMul(factor, corr[i-1]);
		lenChange = disc != '0 && degL <= {1'b0, iterIdx};
		lastStep = bmStepEn && iterIdx == 2'(maxErr - 1);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= '0;
			degL <= '0;
			errLoc.valid <= 1'b0;
		end else begin
			phase <= (bmStart || bmStepEn) ? '0 : phase + 1'b1;
			errLoc.valid <= lastStep;
			if (bmStart)
				degL <= '0;
			else if (bmStepEn && lenChange)
				degL <= {iterIdx, 1'b1} - degL;
		end
	end

	always_ff @(posedge clk) begin
		// even syndromes are squares of the odd ones
		if (syn.valid) begin
			synVal[0] <= '0;
			synVal[1] <= syn.s1;
			synVal[2] <= gfPow(syn.s1, 2);
			synVal[3] <= syn.s3;
			synVal[4] <= gfPow(syn.s1, 4);
			synVal[5] <= syn.s5;
		end

		if (phase == 2'd0)
			disc <= synVal[{iterIdx, 1'b1}] ^ prod;
		else if (!bmStepEn)
			disc <= disc ^ prod;

		if (bmStart) begin
			sigma <= '{'0, '0, '0};
			corr <= '{gfElem'(1), '0, '0};
			dInv <= gfElem'(1);
		end else if (bmStepEn) begin
			sigma <= sigNext;
			corr[0] <= '0;
			if (lenChange) begin
				// corr becomes x^2 times the old locator
				corr[1] <= gfElem'(1);
				corr[2] <= sigma[1];
				dInv <= gfPow(disc, codeLen - 1);
			end else begin
				corr[1] <= '0;
				corr[2] <= corr[0];
			end
		end

		if (lastStep) begin
			errLoc.sigma1 <= sigNext[1];
			errLoc.sigma2 <= sigNext[2];
			errLoc.sigma3 <= sigNext[3];
		end
	end

	// locator degree bounded by the correction capability
	assert property (@(posedge clk) disable iff (reset) degL <= 3'(maxErr));

endmodule

`default_nettype wire

/* hdl/bitDelayBuffer.sv */
`default_nettype none

module bitDelayBuffer (
	input logic clk,
	input logic reset,
	input logic dataIn,
	output logic bufBit
);
	import bchPkg::*;

	// two frames: syndrome frame plus solver frame
	logic [2*codeLen-1:0] shiftReg;

	always_ff @(posedge clk) begin
		if (reset)
			shiftReg <= '0;
		else
			shiftReg <= {shiftReg[2*codeLen-2:0], dataIn};
	end

	assign bufBit = shiftReg[2*codeLen-1];

endmodule

`default_nettype wire

/* hdl/chienSearch.sv */
`default_nettype none

module chienSearch (
	input logic clk,
	input logic reset,
	input logic chienStart,
	input logic bufBit,
	errLocIf.sink errLoc,
	output logic dataOut
);
	import bchPkg::*;

	gfElem sigIn [1:3];
	// term i holds sigma_i * alpha^(i*(p+1)) at position p
	gfElem term [1:3];
	gfElem locSum;
	logic locValid;
	logic errHit;

	assign sigIn[1] = errLoc.sigma1;
	assign sigIn[2] = errLoc.sigma2;
	assign sigIn[3] = errLoc.sigma3;

	always_comb begin
		locSum = '0;
		for (int i = 1; i <= maxErr; i++)
			locSum ^= term[i];
		// sigma0 is 1, so a root gives a sum of 1
		errHit = locSum == gfElem'(1);
	end

	// a fresh locator is consumed by one search
	always_ff @(posedge clk) begin
		if (reset)
			locValid <= 1'b0;
		else if (errLoc.valid)
			locValid <= 1'b1;
		else if (chienStart)
			locValid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		for (int i = 1; i <= maxErr; i++) begin
			if (chienStart)
				term[i] <= locValid ? gfMul(sigIn[i], gfPow(alpha, i)) : '0;
			else
				term[i] <= gfMul(term[i], gfPow(alpha, i));
		end
		dataOut <= bufBit ^ errHit;
	end

endmodule

`default_nettype wire

/* hdl/decodeControl.sv */
`default_nettype none

module decodeControl (
	input logic clk,
	input logic reset,
	output logic synLoad,
	output logic bmStart,
	output logic bmStepEn,
	output logic chienStart,
	output logic outValid,
	output logic [1:0] iterIdx,
	output logic [bchPkg::posWidth-1:0] framePos
);
	import bchPkg::*;

	logic [posWidth-1:0] posCnt;
	logic [1:0] stepCnt;
	logic [1:0] iterCnt;
	logic bmActive;
	// saturates at 2 once the pipeline holds a full codeword
	logic [1:0] frameCnt;
	logic lastPos;
	logic pipeFull;

	assign lastPos = posCnt == posWidth'(codeLen - 1);
	assign pipeFull = frameCnt == 2'd2;

	assign framePos = posCnt;
	assign iterIdx = iterCnt;
	assign synLoad = lastPos;
	// no locator exists yet at the end of frame 0
	assign chienStart = lastPos && frameCnt != 2'd0;
	assign bmStepEn = bmActive && stepCnt == 2'(iterCycles - 1);

	always_ff @(posedge clk) begin
		if (reset) begin
			posCnt <= '0;
			stepCnt <= '0;
			iterCnt <= '0;
			bmActive <= 1'b0;
			bmStart <= 1'b0;
			frameCnt <= '0;
			outValid <= 1'b0;
		end else begin
			posCnt <= lastPos ? '0 : posCnt + 1'b1;
			bmStart <= synLoad;

			if (lastPos && !pipeFull)
				frameCnt <= frameCnt + 1'b1;

			if (bmStart) begin
				stepCnt <= '0;
				iterCnt <= '0;
				bmActive <= 1'b1;
			end else if (bmActive) begin
				stepCnt <= bmStepEn ? '0 : stepCnt + 1'b1;
				if (bmStepEn) begin
					if (iterCnt == 2'(maxErr - 1)) begin
						iterCnt <= '0;
						bmActive <= 1'b0;
					end else begin
						iterCnt <= iterCnt + 1'b1;
					end
				end
			end

			// lines up with the registered dataOut of the Chien stage
			outValid <= pipeFull && posCnt < posWidth'(msgLen);
		end
	end

	// output bits belong to Chien positions 0 to K-1
	assert property (@(posedge clk) disable iff (reset)
		outValid |-> framePos != '0 && framePos <= posWidth'(msgLen));

	// last solver step lands before the Chien stage latches
	assert property (@(posedge clk) disable iff (reset)
		bmStepEn |-> framePos <= posWidth'(maxErr * iterCycles));

endmodule

`default_nettype wire

/* hdl/syndromeCalc.sv */
`default_nettype none

module syndromeCalc (
	input logic clk,
	input logic reset,
	input logic dataIn,
	input logic synLoad,
	syndromeIf.source syn
);
	import bchPkg::*;

	// accumulators for S1, S3, S5
	gfElem acc [maxErr];
	gfElem accNext [maxErr];

	// horner step, the first bit carries the highest degree
	always_comb begin
		for (int j = 0; j < maxErr; j++)
			accNext[j] = gfMul(acc[j], gfPow(alpha, 2 * j + 1)) ^ gfElem'(dataIn);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int j = 0; j < maxErr; j++)
				acc[j] <= '0;
			syn.valid <= 1'b0;
		end else begin
			syn.valid <= synLoad;
			for (int j = 0; j < maxErr; j++)
				acc[j] <= synLoad ? '0 : accNext[j];
		end
	end

	// last bit of the frame is folded in on the way out
	always_ff @(posedge clk) begin
		if (synLoad) begin
			syn.s1 <= accNext[0];
			syn.s3 <= accNext[1];
			syn.s5 <= accNext[2];
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module bchDecoderTb \
	-f compile.f -o bchDecoderSim > sim.log 2>&1 \
	&& ./obj_dir/bchDecoderSim >> sim.log 2>&1 \
	|| echo "Simulation FAILED" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0

/* tb/bchDecoderTb.sv */
`default_nettype none

module bchDecoderTb;
	import bchPkg::*;

	// x^10 + x^8 + x^5 + x^4 + x^2 + x + 1
	localparam logic [10:0] genPoly = 11'h537;
	localparam int parLen = codeLen - msgLen;
	localparam int fillCycles = 2 * codeLen;
	localparam int driveDelay = 1;

	logic clk;
	logic reset;
	logic resetReq;
	logic dataIn;
	logic dataOut;
	logic outValid;

	logic [codeLen-1:0] cwList [$];
	logic [msgLen-1:0] msgList [$];
	string labelList [$];
	// messages in flight, oldest first
	logic [msgLen-1:0] expQueue [$];
	string nameQueue [$];

	int errorCount;
	int passCount;
	int resetCount;
	int cycleCnt;
	int cycleLimit;
	bit limitReady;

	clockGen clkGen_i (
		.resetReq(resetReq),
		.clk(clk),
		.reset(reset)
	);

	bchDecoder dut_i (
		.clk(clk),
		.reset(reset),
		.dataIn(dataIn),
		.dataOut(dataOut),
		.outValid(outValid)
	);

	// systematic encoding, message on top
	function automatic logic [codeLen-1:0] encodeMessage(input logic [msgLen-1:0] msg);
		logic [codeLen-1:0] rem;
		rem = {msg, {parLen{1'b0}}};
		for (int i = codeLen - 1; i >= parLen; i--) begin
			if (rem[i])
				rem ^= {4'b0, genPoly} << (i - parLen);
		end
		return {msg, rem[parLen-1:0]};
	endfunction

	function automatic logic [codeLen-1:0] addRandomErrors(input logic [codeLen-1:0] cw);
		logic [codeLen-1:0] mask;
		int flips;
		int pos;
		mask = '0;
		flips = $urandom % (maxErr + 1);
		while ($countones(mask) < flips) begin
			pos = $urandom % codeLen;
			mask[pos] = 1'b1;
		end
		return cw ^ mask;
	endfunction

	task automatic loadStimulus();
		int fd;
		string line;
		string name;
		logic [codeLen-1:0] cw;
		logic [msgLen-1:0] msg;
		fd = $fopen("tb/bch_stim.txt", "r");
		if (fd == 0) begin
			$display("error: cannot open tb/bch_stim.txt");
			errorCount++;
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) > 0 && $sscanf(line, "%h %h %s", cw, msg, name) == 3) begin
					cwList.push_back(cw);
					msgList.push_back(msg);
					labelList.push_back(name);
					if (name.len() >= 5 && name.substr(0, 4) == "reset")
						resetCount++;
				end
			end
			$fclose(fd);
		end
		if (cwList.size() == 0) begin
			$display("error: no tests found in the stimulus file");
			errorCount++;
		end
	endtask

	task automatic sendBit(input logic b);
		dataIn = b;
		@(posedge clk);
		#driveDelay;
	endtask

	// first bit on the wire is bit 14
	task automatic sendCodeword(input logic [codeLen-1:0] cw);
		for (int i = codeLen - 1; i >= 0; i--)
			sendBit(cw[i]);
	endtask

	task automatic sendIdle(input int cycles);
		repeat (cycles) sendBit(1'b0);
	endtask

	task automatic restartDecoder();
		dataIn = 1'b0;
		resetReq = 1'b1;
		@(negedge reset);
		resetReq = 1'b0;
	endtask

	task automatic checkMessage(input logic [msgLen-1:0] got);
		logic [msgLen-1:0] exp;
		string name;
		if (expQueue.size() == 0) begin
			$display("error at %0t: decoder produced a message with no codeword pending", $time);
			errorCount++;
		end else begin
			exp = expQueue.pop_front();
			name = nameQueue.pop_front();
			assert (got == exp) begin
				passCount++;
				$display("test %s: message %h ok", name, got);
			end else begin
				$display("FAIL time %0t test %s: dataOut expected %h got %h",
					$time, name, exp, got);
				errorCount++;
			end
		end
	endtask

	initial begin
		logic [codeLen-1:0] cw;
		logic [msgLen-1:0] msg;
		string name;
		dataIn = 1'b0;
		resetReq = 1'b0;
		errorCount = 0;
		passCount = 0;
		resetCount = 0;
		void'($urandom(32'hf908_a8ce));
		loadStimulus();
		cycleLimit = (cwList.size() + 4 + 2 * resetCount) * codeLen;
		limitReady = 1'b1;
		@(negedge reset);
		for (int t = 0; t < cwList.size(); t++) begin
			cw = cwList[t];
			msg = msgList[t];
			name = labelList[t];
			if (name.len() >= 5 && name.substr(0, 4) == "reset") begin
				// let the pipeline drain before the restart
				sendIdle(fillCycles);
				restartDecoder();
			end
			if (name.len() >= 6 && name.substr(0, 5) == "random") begin
				msg = msgLen'($urandom);
				cw = addRandomErrors(encodeMessage(msg));
			end
			expQueue.push_back(msg);
			nameQueue.push_back(name);
			sendCodeword(cw);
		end
		sendIdle(fillCycles + 2);
		assert (expQueue.size() == 0) else begin
			$display("error: %0d codewords never came out of the decoder", expQueue.size());
			errorCount++;
		end
		$display("%0d tests run, %0d passed, %0d errors", cwList.size(), passCount, errorCount);
		if (errorCount == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// output monitor, sampled away from the clock edge
	initial begin
		int sinceReset;
		int bitCount;
		logic [msgLen-1:0] got;
		sinceReset = 0;
		bitCount = 0;
		got = '0;
		forever begin
			@(negedge clk);
			if (reset) begin
				sinceReset = 0;
				bitCount = 0;
			end else begin
				sinceReset++;
				if (sinceReset <= fillCycles) begin
					assert (!outValid) else begin
						$display("error at %0t: outValid high while the pipeline fills", $time);
						errorCount++;
					end
				end
				if (outValid) begin
					got = {got[msgLen-2:0], dataOut};
					bitCount++;
				end else if (bitCount != 0) begin
					$display("error at %0t: frame gave %0d valid bits instead of %0d",
						$time, bitCount, msgLen);
					errorCount++;
					bitCount = 0;
				end
				if (bitCount == msgLen) begin
					bitCount = 0;
					checkMessage(got);
				end
			end
		end
	end

	initial begin
		cycleCnt = 0;
		wait (limitReady);
		while (cycleCnt < cycleLimit) begin
			@(posedge clk);
			cycleCnt++;
		end
		$display("timeout: the run did not finish within %0d cycles", cycleLimit);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/bch_stim.txt */
# columns: received codeword (hex, bit 14 sent first), expected message (hex), label
# reset_* restarts the decoder before the line, random_* codewords are built by the testbench
5647 15 clean_mixed
6DC2 13 one_err_msg
323C 0C one_err_parity
257A 19 two_err_msg
1981 06 two_err_parity
4AEF 02 three_err_spread
1DFB 04 three_err_msg
21F4 08 three_err_parity
42DA 10 parity_only_two
0413 01 parity_only_three
0000 00 clean_zeros
7FFF 1F clean_ones
7BFF 1F one_err_ones
29B8 0A reset_clean
464F 15 after_reset_two_err
0000 00 random_a
0000 00 random_b
0000 00 random_c

/* tb/clockGen.sv */
`default_nettype none

module clockGen (
	input logic resetReq,
	output logic clk,
	output logic reset
);
	localparam int period = 40;
	localparam int resetCycles = 3;

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// power-on reset, then one more for every request
	initial begin
		reset = 1'b1;
		forever begin
			repeat (resetCycles) @(posedge clk);
			#1 reset = 1'b0;
			@(posedge resetReq);
			reset = 1'b1;
		end
	end

endmodule

`default_nettype wire
